// File: logic/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor import fetch_pkg::*; #(
    parameter int PHT_BITS    = 6,
    parameter int BTB_ENTRIES = 16
) (
    input  logic                clock,
    input  logic                reset,
    fetch_bp_if.predictor       bp,
    input  logic                resolve_valid,
    input  addr_t               resolve_pc,
    input  logic                resolve_taken,
    input  addr_t               resolve_target,
    input  logic [GHR_BITS-1:0] resolve_ghr,
    input  logic                mispredict,
    input  logic [GHR_BITS-1:0] recover_ghr
);

    localparam int PHT_SIZE = 2 ** PHT_BITS;
    localparam int BTB_BITS = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG  = 30 - BTB_BITS;

    // Two-bit counters and a direct-mapped BTB
    logic [1:0]         pht        [PHT_SIZE];
    logic               btb_valid  [BTB_ENTRIES];
    logic [BTB_TAG-1:0] btb_tag    [BTB_ENTRIES];
    addr_t              btb_target [BTB_ENTRIES];
    // Speculative history
    logic [GHR_BITS-1:0] ghr;

    logic [PHT_BITS-1:0] rd_idx;
    logic [PHT_BITS-1:0] wr_idx;
    logic [BTB_BITS-1:0] rd_slot;
    logic [BTB_BITS-1:0] wr_slot;
    logic                btb_hit;
    logic [1:0]          wr_count;

    // --------------------
    // Lookup
    // --------------------
    // gshare index: pc word bits xor history
    assign rd_idx  = bp.req_pc[2 +: PHT_BITS] ^ PHT_BITS'(ghr);
    assign rd_slot = bp.req_pc[2 +: BTB_BITS];
    assign btb_hit = btb_valid[rd_slot] && btb_tag[rd_slot] == bp.req_pc[31 -: BTB_TAG];

    // Taken needs a known target and counter in upper half
    assign bp.resp_taken        = btb_hit && pht[rd_idx][1];
    assign bp.resp_target       = btb_target[rd_slot];
    assign bp.resp_ghr_snapshot = ghr;

    // --------------------
    // Training
    // --------------------
    assign wr_idx  = resolve_pc[2 +: PHT_BITS] ^ PHT_BITS'(resolve_ghr);
    assign wr_slot = resolve_pc[2 +: BTB_BITS];

    // Saturating step toward the outcome
    always_comb begin
        wr_count = pht[wr_idx];
        if (resolve_taken && wr_count != 2'b11) begin
            wr_count = wr_count + 2'd1;
        end else if (!resolve_taken && wr_count != 2'b00) begin
            wr_count = wr_count - 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ghr <= '0;
            // Weakly not taken
            for (int i = 0; i < PHT_SIZE; i++) begin
                pht[i] <= 2'b01;
            end
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else begin
            // Recovery wins over a speculative shift
            if (mispredict) begin
                ghr <= recover_ghr;
            end else if (bp.req_valid) begin
                ghr <= {ghr[GHR_BITS-2:0], bp.resp_taken};
            end
            if (resolve_valid) begin
                pht[wr_idx] <= wr_count;
                if (resolve_taken) begin
                    btb_valid[wr_slot] <= 1'b1;
                end
            end
        end
    end

    // BTB payload
    always_ff @(posedge clock) begin
        if (resolve_valid && resolve_taken) begin
            btb_tag[wr_slot]    <= resolve_pc[31 -: BTB_TAG];
            btb_target[wr_slot] <= resolve_target;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_ifc.sv
`timescale 1ns/1ps
`default_nettype none

// Fetch asks for a prediction on the earliest branch of a bundle
// Predictor answers in the same cycle
interface fetch_bp_if import fetch_pkg::*; ();

    logic                req_valid;
    addr_t               req_pc;
    logic                resp_taken;
    addr_t               resp_target;
    logic [GHR_BITS-1:0] resp_ghr_snapshot;

    modport fetch (
        output req_valid, req_pc,
        input  resp_taken, resp_target, resp_ghr_snapshot
    );

    modport predictor (
        input  req_valid, req_pc,
        output resp_taken, resp_target, resp_ghr_snapshot
    );

endinterface

// Four-wide bundle from fetch into the instruction buffer
interface fetch_ib_if import fetch_pkg::*; ();

    logic                               bundle_valid;
    fetch_packet_t [BUNDLE_WIDTH-1:0]   bundle;
    // Fewer than four free entries
    logic                               full;

    modport fetch  (output bundle_valid, bundle, input full);
    modport buffer (input bundle_valid, bundle, output full);

endinterface

`default_nettype wire

// File: logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // --------------------
    // Basic widths
    // --------------------

    // Byte address and raw instruction word
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    // Global history width
    localparam int GHR_BITS = 8;

    // Four instructions per bundle, 16 bytes
    localparam int BUNDLE_WIDTH = 4;
    localparam int BUNDLE_BYTES = 16;

    // Low seven bits of an RV32 instruction
    // Only op_branch changes what fetch does
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111,
        op_other  = 7'b1111111
    } rv_opcode_e;

    // --------------------
    // Packets
    // --------------------

    // One instruction on its way to decode
    typedef struct packed {
        addr_t               pc;
        inst_t               inst;
        logic                is_branch;
        logic                pred_taken;
        addr_t               pred_target;
        logic [GHR_BITS-1:0] ghr_snapshot;
    } fetch_packet_t;

    // One 8-byte line, word 0 at the lower address
    typedef struct packed {
        logic        valid;
        inst_t [1:0] words;
    } cache_line_t;

    // Line lookup from fetch
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } line_req_t;

endpackage

`default_nettype wire

// File: logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; #(
    parameter int PHT_BITS     = 6,
    parameter int BTB_ENTRIES  = 16,
    parameter int IB_DEPTH     = 16,
    parameter int CACHE_LINES  = 16,
    parameter int MISS_LATENCY = 4,
    parameter int MEM_WORDS    = 256
) (
    input  logic                clock,
    input  logic                reset,
    // Program load
    input  logic                prog_write,
    input  addr_t               prog_addr,
    input  inst_t               prog_data,
    // Branch resolution
    input  logic                resolve_valid,
    input  addr_t               resolve_pc,
    input  logic                resolve_taken,
    input  addr_t               resolve_target,
    input  logic [GHR_BITS-1:0] resolve_ghr,
    // Redirect
    input  logic                mispredict,
    input  addr_t               redirect_pc,
    input  logic [GHR_BITS-1:0] recover_ghr,
    // Decode
    output logic                decode_valid,
    input  logic                decode_ready,
    output addr_t               decode_pc,
    output inst_t               decode_inst,
    output logic                decode_is_branch,
    output logic                decode_pred_taken,
    output addr_t               decode_pred_target,
    output logic [GHR_BITS-1:0] decode_ghr
);

    line_req_t     line_req [2];
    cache_line_t   line_data [2];
    fetch_packet_t decode_packet;

    fetch_bp_if bp_bus ();
    fetch_ib_if ib_bus ();

    // --------------------
    // Blocks
    // --------------------
    stage_fetch u_fetch (
        .clock       (clock),
        .reset       (reset),
        .line_req    (line_req),
        .line_data   (line_data),
        .mispredict  (mispredict),
        .redirect_pc (redirect_pc),
        .bp          (bp_bus.fetch),
        .ib          (ib_bus.fetch)
    );

    icache_banked #(
        .CACHE_LINES  (CACHE_LINES),
        .MISS_LATENCY (MISS_LATENCY),
        .MEM_WORDS    (MEM_WORDS)
    ) u_icache (
        .clock      (clock),
        .reset      (reset),
        .line_req   (line_req),
        .line_data  (line_data),
        .prog_write (prog_write),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data)
    );

    branch_predictor #(
        .PHT_BITS    (PHT_BITS),
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_predictor (
        .clock          (clock),
        .reset          (reset),
        .bp             (bp_bus.predictor),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_taken  (resolve_taken),
        .resolve_target (resolve_target),
        .resolve_ghr    (resolve_ghr),
        .mispredict     (mispredict),
        .recover_ghr    (recover_ghr)
    );

    inst_buffer #(
        .IB_DEPTH (IB_DEPTH)
    ) u_buffer (
        .clock         (clock),
        .reset         (reset),
        .mispredict    (mispredict),
        .ib            (ib_bus.buffer),
        .decode_valid  (decode_valid),
        .decode_packet (decode_packet),
        .decode_ready  (decode_ready)
    );

    // Head entry split into the decode ports
    assign decode_pc          = decode_packet.pc;
    assign decode_inst        = decode_packet.inst;
    assign decode_is_branch   = decode_packet.is_branch;
    assign decode_pred_taken  = decode_packet.pred_taken;
    assign decode_pred_target = decode_packet.pred_target;
    assign decode_ghr         = decode_packet.ghr_snapshot;

endmodule

`default_nettype wire

// File: logic/icache_banked.sv
`timescale 1ns/1ps
`default_nettype none

module icache_banked import fetch_pkg::*; #(
    parameter int CACHE_LINES  = 16,
    parameter int MISS_LATENCY = 4,
    parameter int MEM_WORDS    = 256
) (
    input  logic        clock,
    input  logic        reset,
    input  line_req_t   line_req [2],
    output cache_line_t line_data [2],
    input  logic        prog_write,
    input  addr_t       prog_addr,
    input  inst_t       prog_data
);

    // Address split: [2] word, [3] bank, then index, then tag
    localparam int IDX_BITS = $clog2(CACHE_LINES);
    localparam int TAG_BITS = 32 - 4 - IDX_BITS;
    localparam int MEM_BITS = $clog2(MEM_WORDS);
    localparam int CNT_BITS = $clog2(MISS_LATENCY + 1);

    typedef enum logic {fill_idle, fill_wait} fill_state_e;

    // Two banks, selected by address bit 3
    logic [TAG_BITS-1:0] tag_mem   [2][CACHE_LINES];
    logic                valid_mem [2][CACHE_LINES];
    inst_t [1:0]         data_mem  [2][CACHE_LINES];
    // Program memory behind the cache
    inst_t               backing   [MEM_WORDS];

    logic [1:0]          hit;
    logic [1:0]          miss;
    fill_state_e         state;
    addr_t               fill_addr;
    logic [CNT_BITS-1:0] fill_count;
    logic                fill_start;
    logic                fill_done;
    logic [MEM_BITS-1:0] fill_word;

    // --------------------
    // Lookup, one per bank
    // --------------------
    for (genvar i = 0; i < 2; i++) begin : g_lookup
        logic                bank;
        logic [IDX_BITS-1:0] idx;
        assign bank = line_req[i].addr[3];
        assign idx  = line_req[i].addr[4 +: IDX_BITS];
        assign hit[i] = valid_mem[bank][idx]
                        && tag_mem[bank][idx] == line_req[i].addr[31 -: TAG_BITS];
        assign miss[i] = line_req[i].valid && !hit[i];
        // Hit data comes back in the request cycle
        assign line_data[i].valid = line_req[i].valid && hit[i];
        assign line_data[i].words = data_mem[bank][idx];
    end

    // --------------------
    // Refill FSM
    // --------------------
    // Lower request first; count includes the miss cycle
    assign fill_start = state == fill_idle && (miss[0] || miss[1]);
    assign fill_done  = state == fill_wait && fill_count >= CNT_BITS'(MISS_LATENCY - 1);
    assign fill_word  = {fill_addr[3 +: MEM_BITS-1], 1'b0};

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= fill_idle;
            fill_count <= '0;
            for (int b = 0; b < 2; b++) begin
                for (int l = 0; l < CACHE_LINES; l++) begin
                    valid_mem[b][l] <= 1'b0;
                end
            end
        end else begin
            if (fill_start) begin
                state      <= fill_wait;
                fill_count <= CNT_BITS'(1);
            end else if (fill_done) begin
                state <= fill_idle;
                valid_mem[fill_addr[3]][fill_addr[4 +: IDX_BITS]] <= 1'b1;
            end else if (state == fill_wait) begin
                fill_count <= fill_count + 1'b1;
            end
            // Program write drops a stale copy, even one filled this edge
            if (prog_write && tag_mem[prog_addr[3]][prog_addr[4 +: IDX_BITS]]
                              == prog_addr[31 -: TAG_BITS]) begin
                valid_mem[prog_addr[3]][prog_addr[4 +: IDX_BITS]] <= 1'b0;
            end
        end
    end

    // Tags, line data and backing words
    always_ff @(posedge clock) begin
        if (fill_start) begin
            fill_addr <= miss[0] ? line_req[0].addr : line_req[1].addr;
        end
        if (fill_done) begin
            tag_mem[fill_addr[3]][fill_addr[4 +: IDX_BITS]] <= fill_addr[31 -: TAG_BITS];
            data_mem[fill_addr[3]][fill_addr[4 +: IDX_BITS]] <=
                {backing[fill_word | MEM_BITS'(1)], backing[fill_word]};
        end
        if (prog_write) begin
            backing[prog_addr[2 +: MEM_BITS]] <= prog_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module inst_buffer import fetch_pkg::*; #(
    parameter int IB_DEPTH = 16
) (
    input  logic          clock,
    input  logic          reset,
    input  logic          mispredict,
    fetch_ib_if.buffer    ib,
    output logic          decode_valid,
    output fetch_packet_t decode_packet,
    input  logic          decode_ready
);

    // Depth is a power of two so pointers wrap on their own
    localparam int PTR_BITS = $clog2(IB_DEPTH);

    fetch_packet_t       entries [IB_DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS:0]   count;
    logic [PTR_BITS:0]   count_next;
    logic [PTR_BITS:0]   push_count;
    logic                pop;

    // --------------------
    // Decode side
    // --------------------
    assign decode_valid  = count != '0;
    assign decode_packet = entries[head];
    // Head holds while decode is not ready
    assign pop = decode_valid && decode_ready;

    // Room check for a whole bundle
    assign ib.full = count > (PTR_BITS + 1)'(IB_DEPTH - BUNDLE_WIDTH);

    // Lanes after a predicted-taken branch are off the predicted path
    always_comb begin
        push_count = (PTR_BITS + 1)'(BUNDLE_WIDTH);
        for (int l = BUNDLE_WIDTH - 1; l >= 0; l--) begin
            if (ib.bundle[l].pred_taken) begin
                push_count = (PTR_BITS + 1)'(l + 1);
            end
        end
    end

    // Up to four in, at most one out
    always_comb begin
        count_next = count;
        if (ib.bundle_valid) begin
            count_next = count_next + push_count;
        end
        if (pop) begin
            count_next = count_next - 1'b1;
        end
    end

    // --------------------
    // Pointers
    // --------------------
    always_ff @(posedge clock) begin
        if (reset || mispredict) begin
            // Flush drops everything fetched so far
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (ib.bundle_valid) begin
                tail <= tail + PTR_BITS'(push_count);
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count_next;
        end
    end

    // Entry storage, lane 0 at the tail
    // Slots past the pushed lanes are free and get overwritten later
    always_ff @(posedge clock) begin
        if (ib.bundle_valid) begin
            for (int l = 0; l < BUNDLE_WIDTH; l++) begin
                entries[tail + PTR_BITS'(l)] <= ib.bundle[l];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/stage_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module stage_fetch import fetch_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    output line_req_t   line_req [2],
    input  cache_line_t line_data [2],
    input  logic        mispredict,
    input  addr_t       redirect_pc,
    fetch_bp_if.fetch   bp,
    fetch_ib_if.fetch   ib
);

    localparam int LANE_BITS = $clog2(BUNDLE_WIDTH);

    addr_t                  pc;
    addr_t                  pc_next;
    inst_t                  lane_inst [BUNDLE_WIDTH];
    logic [BUNDLE_WIDTH-1:0] lane_branch;
    logic                   found;
    logic [LANE_BITS-1:0]   first_lane;
    logic                   lines_ready;
    logic                   accept;

    function automatic logic is_cond_branch(inst_t word);
        return rv_opcode_e'(word[6:0]) == op_branch;
    endfunction

    // --------------------
    // Line requests
    // --------------------
    // PC and PC+8 land in opposite banks
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            line_req[i].valid = !ib.full;
            line_req[i].addr  = pc + addr_t'(8 * i);
        end
    end

    // Lanes 0,1 from the first line, 2,3 from the second
    always_comb begin
        for (int l = 0; l < BUNDLE_WIDTH; l++) begin
            lane_inst[l]   = line_data[l / 2].words[l % 2];
            lane_branch[l] = is_cond_branch(lane_inst[l]);
        end
    end

    assign lines_ready = line_data[0].valid && line_data[1].valid;
    // No bundle in the mispredict cycle
    assign accept = lines_ready && !ib.full && !mispredict;

    // Earliest branch; scan from the top so the lowest lane wins
    always_comb begin
        found      = 1'b0;
        first_lane = '0;
        for (int l = BUNDLE_WIDTH - 1; l >= 0; l--) begin
            if (lane_branch[l]) begin
                found      = 1'b1;
                first_lane = LANE_BITS'(l);
            end
        end
    end

    // --------------------
    // Predictor request
    // --------------------
    // Raised only with an accepted bundle, so it always shifts the GHR
    assign bp.req_valid = accept && found;
    assign bp.req_pc    = pc + addr_t'({first_lane, 2'b00});

    // --------------------
    // Bundle to the buffer
    // --------------------
    // Buffer keeps lanes only up to a predicted-taken branch
    always_comb begin
        for (int l = 0; l < BUNDLE_WIDTH; l++) begin
            ib.bundle[l].pc           = pc + addr_t'(4 * l);
            ib.bundle[l].inst         = lane_inst[l];
            ib.bundle[l].is_branch    = found && first_lane == LANE_BITS'(l);
            ib.bundle[l].pred_taken   = ib.bundle[l].is_branch && bp.resp_taken;
            ib.bundle[l].pred_target  = ib.bundle[l].is_branch ? bp.resp_target : '0;
            ib.bundle[l].ghr_snapshot = ib.bundle[l].is_branch ? bp.resp_ghr_snapshot : '0;
        end
    end

    assign ib.bundle_valid = accept;

    // --------------------
    // Next PC
    // --------------------
    // Redirect, then predicted target, then sequential, else hold
    always_comb begin
        pc_next = pc;
        if (mispredict) begin
            pc_next = redirect_pc;
        end else if (accept && found && bp.resp_taken) begin
            pc_next = bp.resp_target;
        end else if (accept) begin
            pc_next = pc + addr_t'(BUNDLE_BYTES);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f sim.f --top-module fetch_tb -o fetch_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/fetch_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if echo "$output" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1

// File: sim.f
logic/fetch_pkg.sv
logic/fetch_ifc.sv
logic/icache_banked.sv
logic/branch_predictor.sv
logic/stage_fetch.sv
logic/inst_buffer.sv
logic/fetch_top.sv
+incdir+verification
verification/fetch_tb.sv

// File: verification/fetch_tb_tests.svh
`ifndef FETCH_TB_TESTS_SVH
`define FETCH_TB_TESTS_SVH

function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

task automatic apply_reset();
    @(negedge clock);
    reset = 1'b1;
    repeat (5) @(negedge clock);
    reset = 1'b0;
endtask

// Filler words are op_imm, branches sit at 0x114, 0x11c and 0x208
task automatic load_program();
    logic [31:0] r;
    for (int i = 0; i < MEM_WORDS; i++) begin
        r = xorshift();
        program_words[i] = {r[31:7] ^ 25'(i), 7'b0010011};
    end
    program_words[69][6:0]  = 7'b1100011;
    program_words[71][6:0]  = 7'b1100011;
    program_words[130][6:0] = 7'b1100011;
    // Flush held high so nothing reaches the buffer while loading
    mispredict = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
        @(negedge clock);
        prog_write = 1'b1;
        prog_addr  = addr_t'(4 * i);
        prog_data  = program_words[i];
    end
    @(negedge clock);
    prog_write = 1'b0;
    mispredict = 1'b0;
endtask

task automatic model_reset();
    expected.delete();
    model_pc  = '0;
    model_ghr = '0;
    for (int i = 0; i < 64; i++) begin
        model_pht[i] = 2'b01;
    end
    for (int i = 0; i < 16; i++) begin
        model_btb_valid[i] = 1'b0;
    end
endtask

// --------------------
// Model of one bundle
// --------------------
task automatic model_bundle();
    int    first;
    int    last;
    addr_t lane_pc;
    logic  taken;
    logic [3:0] slot;
    logic [5:0] idx;
    dec_t  e;
    first = -1;
    taken = 1'b0;
    for (int l = 0; l < 4; l++) begin
        lane_pc = model_pc + addr_t'(4 * l);
        if (first < 0 && program_words[lane_pc[9:2]][6:0] == 7'b1100011) begin
            first = l;
        end
    end
    if (first >= 0) begin
        lane_pc = model_pc + addr_t'(4 * first);
        slot    = lane_pc[5:2];
        idx     = lane_pc[7:2] ^ model_ghr[5:0];
        taken   = model_btb_valid[slot] && model_btb_pc[slot] == lane_pc
                  && model_pht[idx] >= 2'd2;
    end
    // Lanes after a taken branch never reach decode
    last = taken ? first : 3;
    for (int l = 0; l <= last; l++) begin
        e.pc          = model_pc + addr_t'(4 * l);
        e.inst        = program_words[e.pc[9:2]];
        e.is_branch   = l == first;
        e.pred_taken  = e.is_branch && taken;
        e.pred_target = e.pred_taken ? model_btb_target[slot] : '0;
        e.ghr         = e.is_branch ? model_ghr : '0;
        expected.push_back(e);
    end
    if (first >= 0) begin
        model_ghr = {model_ghr[GHR_BITS-2:0], taken};
    end
    model_pc = taken ? model_btb_target[slot] : model_pc + 32'd16;
endtask

task automatic apply_redirect(input addr_t pc, input logic [GHR_BITS-1:0] ghr);
    @(negedge clock);
    mispredict  = 1'b1;
    redirect_pc = pc;
    recover_ghr = ghr;
    @(negedge clock);
    mispredict = 1'b0;
    expected.delete();
    model_pc  = pc;
    model_ghr = ghr;
endtask

task automatic train_branch(input addr_t pc, input logic taken, input addr_t target,
                            input logic [GHR_BITS-1:0] ghr);
    logic [5:0] idx;
    @(negedge clock);
    resolve_valid  = 1'b1;
    resolve_pc     = pc;
    resolve_taken  = taken;
    resolve_target = target;
    resolve_ghr    = ghr;
    @(negedge clock);
    resolve_valid = 1'b0;
    idx = pc[7:2] ^ ghr[5:0];
    if (taken && model_pht[idx] != 2'b11) begin
        model_pht[idx] = model_pht[idx] + 2'd1;
    end else if (!taken && model_pht[idx] != 2'b00) begin
        model_pht[idx] = model_pht[idx] - 2'd1;
    end
    if (taken) begin
        model_btb_valid[pc[5:2]]  = 1'b1;
        model_btb_pc[pc[5:2]]     = pc;
        model_btb_target[pc[5:2]] = target;
    end
endtask

// --------------------
// Decode side
// --------------------
// Compares each popped instruction with the model, then leaves ready low
task automatic decode_stream(input int count, input logic random_ready);
    int          got;
    int          idle;
    logic [31:0] r;
    dec_t        want;
    dec_t        obs;
    got  = 0;
    idle = 0;
    seen.delete();
    while (got < count) begin
        @(negedge clock);
        r = xorshift();
        decode_ready = random_ready ? r[0] : 1'b1;
        if (decode_valid && decode_ready) begin
            if (expected.size() == 0) begin
                model_bundle();
            end
            want = expected.pop_front();
            check_value("decode_pc", decode_pc, want.pc);
            check_value("decode_inst", decode_inst, want.inst);
            check_value("decode_is_branch", 32'(decode_is_branch), 32'(want.is_branch));
            check_value("decode_pred_taken", 32'(decode_pred_taken), 32'(want.pred_taken));
            check_value("decode_ghr", 32'(decode_ghr), 32'(want.ghr));
            // A cold BTB slot gives no defined target
            if (want.pred_taken) begin
                check_value("decode_pred_target", decode_pred_target, want.pred_target);
            end
            obs.pc          = decode_pc;
            obs.inst        = decode_inst;
            obs.is_branch   = decode_is_branch;
            obs.pred_taken  = decode_pred_taken;
            obs.pred_target = decode_pred_target;
            obs.ghr         = decode_ghr;
            seen.push_back(obs);
            got++;
            idle = 0;
        end else begin
            idle++;
            if (idle > TIMEOUT) begin
                stop_on("Timed out waiting for decode_valid");
            end
        end
    end
    @(negedge clock);
    decode_ready = 1'b0;
endtask

// Stalled decode lets the buffer fill up
task automatic wait_buffer_full();
    int waited;
    waited = 0;
    while (!u_dut.ib_bus.full) begin
        @(negedge clock);
        waited++;
        if (waited > TIMEOUT) begin
            stop_on("Timed out waiting for the instruction buffer to fill");
        end
    end
endtask

// --------------------
// Directed tests
// --------------------
task automatic test_straight_line();
    decode_stream(64, 1'b0);
    for (int i = 0; i < 64; i++) begin
        check_value("decode_pc", seen[i].pc, 32'(4 * i));
        check_value("decode_is_branch", 32'(seen[i].is_branch), 32'd0);
    end
endtask

task automatic test_back_pressure();
    decode_stream(96, 1'b1);
endtask

task automatic test_first_branch();
    apply_redirect(32'h110, '0);
    decode_stream(8, 1'b0);
    check_value("decode_is_branch", 32'(seen[1].is_branch), 32'd1);
    check_value("decode_is_branch", 32'(seen[3].is_branch), 32'd0);
    check_value("decode_pred_taken", 32'(seen[1].pred_taken), 32'd0);
    check_value("decode_pc", seen[4].pc, 32'h120);
endtask

task automatic test_trained_branch();
    train_branch(32'h114, 1'b1, 32'h200, '0);
    apply_redirect(32'h0, '0);
    decode_stream(71, 1'b0);
    check_value("decode_pc", seen[69].pc, 32'h114);
    check_value("decode_pred_taken", 32'(seen[69].pred_taken), 32'd1);
    check_value("decode_pred_target", seen[69].pred_target, 32'h200);
    check_value("decode_ghr", 32'(seen[69].ghr), 32'd0);
    check_value("decode_pc", seen[70].pc, 32'h200);
endtask

// Cold branch at 0x208 sees the taken bit shifted in at 0x114
task automatic test_ghr_snapshot();
    decode_stream(8, 1'b0);
    check_value("decode_pc", seen[1].pc, 32'h208);
    check_value("decode_is_branch", 32'(seen[1].is_branch), 32'd1);
    check_value("decode_ghr", 32'(seen[1].ghr), 32'd1);
endtask

task automatic test_redirect_flush();
    wait_buffer_full();
    apply_redirect(32'h300, '0);
    decode_stream(8, 1'b0);
    check_value("decode_pc", seen[0].pc, 32'h300);
endtask

`endif

// File: verification/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

    localparam int MEM_WORDS = 256;
    // Longest gap between two decoded instructions
    localparam int TIMEOUT = 200;

    // One decoded instruction as the model expects it
    typedef struct packed {
        addr_t               pc;
        inst_t               inst;
        logic                is_branch;
        logic                pred_taken;
        addr_t               pred_target;
        logic [GHR_BITS-1:0] ghr;
    } dec_t;

    logic                clock;
    logic                reset;
    logic                prog_write;
    addr_t               prog_addr;
    inst_t               prog_data;
    logic                resolve_valid;
    addr_t               resolve_pc;
    logic                resolve_taken;
    addr_t               resolve_target;
    logic [GHR_BITS-1:0] resolve_ghr;
    logic                mispredict;
    addr_t               redirect_pc;
    logic [GHR_BITS-1:0] recover_ghr;
    logic                decode_valid;
    logic                decode_ready;
    addr_t               decode_pc;
    inst_t               decode_inst;
    logic                decode_is_branch;
    logic                decode_pred_taken;
    addr_t               decode_pred_target;
    logic [GHR_BITS-1:0] decode_ghr;

    // --------------------
    // Reference model state
    // --------------------
    logic [31:0]         rng_state;
    inst_t               program_words [MEM_WORDS];
    dec_t                expected [$];
    dec_t                seen [$];
    addr_t               model_pc;
    logic [GHR_BITS-1:0] model_ghr;
    logic [1:0]          model_pht [64];
    logic                model_btb_valid [16];
    addr_t               model_btb_pc [16];
    addr_t               model_btb_target [16];

    fetch_top #(
        .MEM_WORDS (MEM_WORDS)
    ) u_dut (
        .clock              (clock),
        .reset              (reset),
        .prog_write         (prog_write),
        .prog_addr          (prog_addr),
        .prog_data          (prog_data),
        .resolve_valid      (resolve_valid),
        .resolve_pc         (resolve_pc),
        .resolve_taken      (resolve_taken),
        .resolve_target     (resolve_target),
        .resolve_ghr        (resolve_ghr),
        .mispredict         (mispredict),
        .redirect_pc        (redirect_pc),
        .recover_ghr        (recover_ghr),
        .decode_valid       (decode_valid),
        .decode_ready       (decode_ready),
        .decode_pc          (decode_pc),
        .decode_inst        (decode_inst),
        .decode_is_branch   (decode_is_branch),
        .decode_pred_taken  (decode_pred_taken),
        .decode_pred_target (decode_pred_target),
        .decode_ghr         (decode_ghr)
    );

    // 8 ns clock
    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %s got 0x%08h expected 0x%08h", name, got, want);
            $display("Finished with errors");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic stop_on(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "run stopped");
    endtask

    `include "fetch_tb_tests.svh"

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        reset          = 1'b1;
        prog_write     = 1'b0;
        prog_addr      = '0;
        prog_data      = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_taken  = 1'b0;
        resolve_target = '0;
        resolve_ghr    = '0;
        mispredict     = 1'b0;
        redirect_pc    = '0;
        recover_ghr    = '0;
        decode_ready   = 1'b0;
        rng_state      = 32'd56;

        apply_reset();
        load_program();
        // Second reset drops anything cached while loading
        apply_reset();
        model_reset();

        test_straight_line();
        test_back_pressure();
        test_first_branch();
        test_trained_branch();
        test_ghr_snapshot();
        test_redirect_flush();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
